/* Bender.yml */
package:
  name: l2_tlb

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/l2_tlb_pkg.sv
      - verilog/l2_tlb_mshr.sv
      - verilog/l2_tlb_array.sv
      - verilog/l2_tlb_ctrl.sv
      - verilog/l2_tlb_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_l2_tlb.sv

/* build.f */
+incdir+verilog
verilog/l2_tlb_pkg.sv
verilog/l2_tlb_mshr.sv
verilog/l2_tlb_array.sv
verilog/l2_tlb_ctrl.sv
verilog/l2_tlb_top.sv
testbench/tb_l2_tlb.sv

/* testbench/tb_l2_tlb.sv */
// L2 TLB testbench
// Drives ITLB/DTLB misses, models the page-table walker and checks each response

`timescale 1ns/10ps

`include "l2_tlb_config.svh"

module tb_l2_tlb;

  import l2_tlb_pkg::*;

  localparam time CLK_PERIOD = 20ns;
  localparam int  NUM_REQS   = 218;
  localparam int  IDX_W      = $clog2(`L2_TLB_SETS);

  logic      clk_i;
  logic      rst_ni;
  logic      flush_i;
  logic      req_valid_i;
  tlb_req_t  req_i;
  logic      busy_o;
  logic      resp_valid_o;
  tlb_resp_t resp_o;
  logic      ptw_req_o;
  vpn_t      ptw_req_vpn_o;
  logic      ptw_ans_valid_i;
  ppn_t      ptw_ans_ppn_i;

  // Accepted requests without response, and misses still owed a walk
  tlb_req_t    pending[$];
  vpn_t        walk_exp[$];
  // Own copy of the direct-mapped array
  logic        model_valid [`L2_TLB_SETS];
  vpn_t        model_vpn [`L2_TLB_SETS];
  logic [31:0] lfsr_q = 32'h7735_2bb0;
  logic        slow_ptw = 1'b0;
  logic        walk_busy = 1'b0;
  int          walk_count = 0;
  int          stall_cycles = 0;
  int          error_count = 0;
  string       test_name = "reset";

  l2_tlb_top dut (.*);

  // Expected PPN as the 16-bit VPN folded into 12 bits
  function automatic ppn_t ppn_of(input vpn_t vpn);
    return vpn[11:0] ^ {vpn[15:12], vpn[15:12], vpn[15:12]};
  endfunction

  function automatic logic model_hit(input vpn_t vpn);
    logic [IDX_W-1:0] idx;
    idx = vpn[IDX_W-1:0];
    return model_valid[idx] &&
           (model_vpn[idx][`L2_TLB_VPN_W-1:IDX_W] == vpn[`L2_TLB_VPN_W-1:IDX_W]);
  endfunction

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      report_error($sformatf("ERR %s %s expected %0h actual %0h",
                             test_name, what, expected, actual));
    end
  endtask

  // Holds the request until busy_o lets it in
  // Called just after a rising edge
  task automatic send_req(input vpn_t vpn, input tlb_dest_e dest);
    logic accepted;
    accepted    = 1'b0;
    req_valid_i = 1'b1;
    req_i       = '{vpn: vpn, dest: dest};
    while (!accepted) begin
      @(negedge clk_i);
      if (!busy_o) begin
        accepted = 1'b1;
        pending.push_back(req_i);
        if (!model_hit(vpn)) begin
          walk_exp.push_back(vpn);
        end
      end else begin
        stall_cycles++;
      end
      @(posedge clk_i);
      #2;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending.size() != 0 || walk_exp.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    #2;
  endtask

  task automatic do_flush();
    flush_i = 1'b1;
    foreach (model_valid[i]) model_valid[i] = 1'b0;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // PTW model answering one walk at a time 3 to 10 cycles after the request
  initial begin
    vpn_t        vpn;
    logic [31:0] bits;
    int          delay;
    forever begin
      @(negedge clk_i);
      if (rst_ni && ptw_req_o) begin
        vpn = ptw_req_vpn_o;
        walk_count++;
        if (walk_exp.size() == 0) begin
          report_error($sformatf("Walk requested for vpn %h while no miss was waiting", vpn));
        end
        compare("walk order", walk_exp.pop_front(), vpn);
        take_bits(3, bits);
        delay = 3 + int'(bits) + (slow_ptw ? 20 : 0);
        @(posedge clk_i);
        walk_busy = 1'b1;
        repeat (delay - 1) @(posedge clk_i);
        #2;
        ptw_ans_valid_i = 1'b1;
        ptw_ans_ppn_i   = ppn_of(vpn);
        @(posedge clk_i);
        // Fill lands on this edge so later lookups see it
        model_valid[vpn[IDX_W-1:0]] = 1'b1;
        model_vpn[vpn[IDX_W-1:0]]   = vpn;
        #2;
        ptw_ans_valid_i = 1'b0;
        walk_busy       = 1'b0;
      end
    end
  end

  // Second walk request while one is still running
  always @(negedge clk_i) begin
    if (rst_ni && ptw_req_o && walk_busy) begin
      report_error("A second walk was requested before the first was answered");
    end
  end

  // Responses match any open request since hits may overtake misses
  always @(negedge clk_i) begin
    int idx;
    idx = -1;
    if (rst_ni && resp_valid_o) begin
      compare("resp ppn", ppn_of(resp_o.vpn), resp_o.ppn);
      for (int i = 0; i < pending.size(); i++) begin
        if (idx < 0 && pending[i].vpn == resp_o.vpn && pending[i].dest == resp_o.dest) begin
          idx = i;
        end
      end
      if (idx < 0) begin
        report_error($sformatf("Response for vpn %h dest %0d matches no open request",
                               resp_o.vpn, resp_o.dest));
      end else begin
        pending.delete(idx);
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (NUM_REQS * 40 + 500));
    report_error("Timeout, the tests did not finish in time");
  end

  initial begin
    logic [31:0] bits;
    int          walks_before;
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    req_valid_i     = 1'b0;
    req_i           = '0;
    ptw_ans_valid_i = 1'b0;
    ptw_ans_ppn_i   = '0;
    foreach (model_valid[i]) model_valid[i] = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // Cold misses from both requesters
    test_name = "cold_miss";
    send_req(16'h0010, ITLB);
    send_req(16'h0021, DTLB);
    send_req(16'h1032, ITLB);
    wait_drain();
    // Refilled VPNs hit without a walk
    test_name    = "hit";
    walks_before = walk_count;
    send_req(16'h0010, DTLB);
    send_req(16'h0021, DTLB);
    wait_drain();
    compare("walks on hit", walks_before, walk_count);
    // Back-to-back misses whose walk order the PTW model checks
    test_name = "walk_order";
    send_req(16'h0100, ITLB);
    send_req(16'h0201, DTLB);
    send_req(16'h0302, ITLB);
    send_req(16'h0403, DTLB);
    wait_drain();
    // Slow PTW lets the MSHR fill so busy_o stalls the sixth request
    test_name = "mshr_full";
    slow_ptw  = 1'b1;
    for (int i = 0; i < 5; i++) begin
      send_req(16'h2000 + 16'(i), tlb_dest_e'(i[0]));
    end
    stall_cycles = 0;
    send_req(16'h2005, DTLB);
    compare("stall under full MSHR", 1, stall_cycles > 10);
    wait_drain();
    slow_ptw = 1'b0;
    // Flush turns a hit back into a miss
    test_name = "flush";
    send_req(16'h3037, ITLB);
    wait_drain();
    walks_before = walk_count;
    send_req(16'h3037, DTLB);
    wait_drain();
    compare("walks before flush", walks_before, walk_count);
    do_flush();
    send_req(16'h3037, ITLB);
    wait_drain();
    compare("walks after flush", walks_before + 1, walk_count);
    // Random mix over 64 VPNs with 4 tags per set
    test_name = "random";
    for (int i = 0; i < 200; i++) begin
      take_bits(9, bits);
      send_req(vpn_t'(bits[5:0]), tlb_dest_e'(bits[6]));
      repeat (bits[8:7]) begin
        @(posedge clk_i);
        #2;
      end
    end
    wait_drain();
    if (error_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_error("Checks failed during the run");
    end
  end

endmodule

/* verilog/l2_tlb_array.sv */
// L2 TLB translation array
// Direct-mapped VPN to PPN store with registered lookup, fill and flush

`timescale 1ns/10ps

`include "l2_tlb_config.svh"

module l2_tlb_array #(
  parameter int unsigned SETS = `L2_TLB_SETS
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             lookup_i,
  input  logic             fill_i,
  input  l2_tlb_pkg::vpn_t lookup_vpn_i,
  input  l2_tlb_pkg::vpn_t fill_vpn_i,
  input  l2_tlb_pkg::ppn_t fill_ppn_i,
  output logic             lookup_done_o,
  output logic             hit_o,
  output l2_tlb_pkg::ppn_t ppn_o
);

  import l2_tlb_pkg::*;

  localparam int unsigned IDX_W = $clog2(SETS);
  localparam int unsigned TAG_W = `L2_TLB_VPN_W - IDX_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  logic [SETS-1:0] valid_q;
  tag_t            tag_q [SETS];
  ppn_t            ppn_q [SETS];
  idx_t            lookup_idx;
  idx_t            fill_idx;
  tag_t            lookup_tag;
  tag_t            fill_tag;
  logic            done_q;
  logic            hit_q;
  ppn_t            rd_ppn_q;

  // Index from low VPN bits, tag from the rest
  assign lookup_idx = lookup_vpn_i[IDX_W-1:0];
  assign lookup_tag = lookup_vpn_i[`L2_TLB_VPN_W-1:IDX_W];
  assign fill_idx   = fill_vpn_i[IDX_W-1:0];
  assign fill_tag   = fill_vpn_i[`L2_TLB_VPN_W-1:IDX_W];

  // Flush wins over a fill in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  // A fill simply overwrites the set
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      tag_q[fill_idx] <= fill_tag;
      ppn_q[fill_idx] <= fill_ppn_i;
    end
  end

  // Lookup reads the old contents, a concurrent fill shows up next time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
      hit_q  <= 1'b0;
    end else begin
      done_q <= lookup_i;
      hit_q  <= lookup_i & ~flush_i & valid_q[lookup_idx] &
                (tag_q[lookup_idx] == lookup_tag);
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      rd_ppn_q <= ppn_q[lookup_idx];
    end
  end

  assign lookup_done_o = done_q;
  assign hit_o         = hit_q;
  assign ppn_o         = rd_ppn_q;

endmodule

/* verilog/l2_tlb_config.svh */
// L2 TLB configuration
// Widths and sizes shared by the package and the RTL modules

`ifndef L2_TLB_CONFIG_SVH
`define L2_TLB_CONFIG_SVH

// Virtual page number width
`define L2_TLB_VPN_W 16

// Physical page number width
`define L2_TLB_PPN_W 12

// Sets in the direct-mapped translation array
`define L2_TLB_SETS 16

// Pending misses held in the MSHR FIFO, not counting the waiting slot
`define L2_TLB_MSHR_ENTRIES 4

`endif

/* verilog/l2_tlb_ctrl.sv */
// L2 TLB miss controller
// Turns lookup results, MSHR status and PTW answers into responses,
// MSHR updates, array fills and walk requests

`timescale 1ns/10ps

module l2_tlb_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  req_valid_i,
  input  l2_tlb_pkg::tlb_req_t  req_i,
  output logic                  busy_o,
  output logic                  resp_valid_o,
  output l2_tlb_pkg::tlb_resp_t resp_o,
  output logic                  lookup_o,
  output l2_tlb_pkg::vpn_t      lookup_vpn_o,
  output logic                  fill_o,
  output l2_tlb_pkg::vpn_t      fill_vpn_o,
  output l2_tlb_pkg::ppn_t      fill_ppn_o,
  input  logic                  lookup_done_i,
  input  logic                  hit_i,
  input  l2_tlb_pkg::ppn_t      ppn_i,
  output logic                  add_entry_o,
  output logic                  let_entry_waiting_o,
  output logic                  rm_entry_o,
  output l2_tlb_pkg::tlb_req_t  add_req_o,
  input  logic                  req_available_i,
  input  logic                  mshr_full_i,
  input  l2_tlb_pkg::vpn_t      ptw_ans_vpn_i,
  input  l2_tlb_pkg::tlb_dest_e ptw_ans_dest_i,
  output logic                  ptw_req_o,
  input  logic                  ptw_ans_valid_i,
  input  l2_tlb_pkg::ppn_t      ptw_ans_ppn_i
);

  import l2_tlb_pkg::*;

  walk_state_e state_q;
  walk_state_e state_d;
  tlb_req_t    req_q;
  tlb_resp_t   hit_resp;
  tlb_resp_t   fresp_q;
  tlb_resp_t   skid_q;
  logic        fresp_valid_q;
  logic        skid_valid_q;
  logic        accept;
  logic        hit_now;

  // One request per two cycles at most
  assign busy_o = lookup_done_i | mshr_full_i | skid_valid_q;
  assign accept = req_valid_i & ~busy_o;

  // Lookup launched on acceptance, request kept for the result cycle
  assign lookup_o     = accept;
  assign lookup_vpn_o = req_i.vpn;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  assign hit_now  = lookup_done_i & hit_i;
  assign hit_resp = '{vpn: req_q.vpn, ppn: ppn_i, dest: req_q.dest};

  // Misses queue in arrival order
  assign add_entry_o = lookup_done_i & ~hit_i;
  assign add_req_o   = req_q;

  // Walk FSM, head of the MSHR starts a walk when none is running
  always_comb begin
    state_d             = state_q;
    ptw_req_o           = 1'b0;
    let_entry_waiting_o = 1'b0;
    rm_entry_o          = 1'b0;
    case (state_q)
      WALK_IDLE: begin
        if (req_available_i) begin
          ptw_req_o           = 1'b1;
          let_entry_waiting_o = 1'b1;
          state_d             = WALK_BUSY;
        end
      end
      WALK_BUSY: begin
        if (ptw_ans_valid_i) begin
          rm_entry_o = 1'b1;
          state_d    = WALK_IDLE;
        end
      end
      default: state_d = WALK_IDLE;
    endcase
  end

  // Answer refills the array in its own cycle
  assign fill_o     = ptw_ans_valid_i;
  assign fill_vpn_o = ptw_ans_vpn_i;
  assign fill_ppn_o = ptw_ans_ppn_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= WALK_IDLE;
      fresp_valid_q <= 1'b0;
      skid_valid_q  <= 1'b0;
    end else begin
      state_q       <= state_d;
      fresp_valid_q <= ptw_ans_valid_i;
      // Hit parked behind a fill response, drained once the port is free
      if (hit_now && (fresp_valid_q || skid_valid_q)) begin
        skid_valid_q <= 1'b1;
      end else if (!fresp_valid_q) begin
        skid_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ptw_ans_valid_i) begin
      fresp_q <= '{vpn: ptw_ans_vpn_i, ppn: ptw_ans_ppn_i, dest: ptw_ans_dest_i};
    end
    if (hit_now && (fresp_valid_q || skid_valid_q)) begin
      skid_q <= hit_resp;
    end
  end

  // Fill response first, then skid, then a fresh hit
  assign resp_valid_o = fresp_valid_q | skid_valid_q | hit_now;
  assign resp_o       = fresp_valid_q ? fresp_q :
                        skid_valid_q  ? skid_q  : hit_resp;

  // PTW answers only the walk in progress
  ans_in_walk_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ptw_ans_valid_i |-> state_q == WALK_BUSY);
  // Flush with nothing in flight or queued
  flush_idle_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> state_q == WALK_IDLE && !req_available_i && !lookup_done_i);

endmodule

/* verilog/l2_tlb_mshr.sv */
// L2 TLB miss status holding registers
// In-order FIFO of missed VPNs without holes, plus one waiting slot
// that holds the VPN whose page walk is in progress

`timescale 1ns/10ps

`include "l2_tlb_config.svh"

module l2_tlb_mshr #(
  parameter int unsigned N = `L2_TLB_MSHR_ENTRIES
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clr_mshr_i,
  input  logic                  add_entry_i,
  input  logic                  rm_entry_i,
  input  logic                  let_entry_waiting_i,
  input  l2_tlb_pkg::vpn_t      vpn_i,
  input  l2_tlb_pkg::tlb_dest_e destination_i,
  output logic                  req_available_o,
  output logic                  mshr_full_o,
  output l2_tlb_pkg::vpn_t      ptw_req_vpn_o,
  output l2_tlb_pkg::vpn_t      ptw_ans_vpn_o,
  output l2_tlb_pkg::tlb_dest_e destination_o
);

  import l2_tlb_pkg::*;

  localparam int unsigned PTR_W = $clog2(N);

  // FIFO storage, a place is occupied while its valid bit is set
  tlb_req_t         entry_q [N];
  logic [N-1:0]     valid_q;
  logic [PTR_W-1:0] free_ptr_q;
  logic [PTR_W-1:0] older_ptr_q;

  // Entry under walk, leaves the FIFO when it moves here
  tlb_req_t         waiting_q;
  logic             waiting_valid_q;

  // Pointers wrap after the last entry
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(N - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Add and hand-over may coincide, both pointers then advance
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_ptr_q  <= '0;
      older_ptr_q <= '0;
      valid_q     <= '0;
    end else if (clr_mshr_i) begin
      free_ptr_q  <= '0;
      older_ptr_q <= '0;
      valid_q     <= '0;
    end else begin
      if (add_entry_i) begin
        free_ptr_q          <= next_ptr(free_ptr_q);
        valid_q[free_ptr_q] <= 1'b1;
      end
      if (let_entry_waiting_i) begin
        older_ptr_q          <= next_ptr(older_ptr_q);
        valid_q[older_ptr_q] <= 1'b0;
      end
    end
  end

  // Payload written at the free place
  always_ff @(posedge clk_i) begin
    if (add_entry_i) begin
      entry_q[free_ptr_q].vpn  <= vpn_i;
      entry_q[free_ptr_q].dest <= destination_i;
    end
  end

  // Oldest entry copied into the waiting slot when its walk starts
  always_ff @(posedge clk_i) begin
    if (let_entry_waiting_i) begin
      waiting_q <= entry_q[older_ptr_q];
    end
  end

  // Slot is busy from the walk request until the answer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      waiting_valid_q <= 1'b0;
    end else if (clr_mshr_i) begin
      waiting_valid_q <= 1'b0;
    end else if (let_entry_waiting_i) begin
      waiting_valid_q <= 1'b1;
    end else if (rm_entry_i) begin
      waiting_valid_q <= 1'b0;
    end
  end

  // Status
  assign mshr_full_o     = &valid_q;
  assign req_available_o = |valid_q;

  // Head feeds the walk request, waiting slot tags the answer
  assign ptw_req_vpn_o = entry_q[older_ptr_q].vpn;
  assign ptw_ans_vpn_o = waiting_q.vpn;
  assign destination_o = waiting_q.dest;

  // Controller must respect busy and walk order
  add_not_full_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    add_entry_i |-> !mshr_full_o);
  let_not_empty_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    let_entry_waiting_i |-> req_available_o);
  // An answer always follows a handed-over entry
  rm_after_let_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rm_entry_i |-> waiting_valid_q);

endmodule

/* verilog/l2_tlb_pkg.sv */
// L2 TLB package
// Page number types, requester and walk-state encodings, request and response structs

`include "l2_tlb_config.svh"

package l2_tlb_pkg;

  // Page numbers
  typedef logic [`L2_TLB_VPN_W-1:0] vpn_t;
  typedef logic [`L2_TLB_PPN_W-1:0] ppn_t;

  // Requester of a translation, returned with the response
  typedef enum logic {
    ITLB = 1'b0,
    DTLB = 1'b1
  } tlb_dest_e;

  // One walk in flight at most
  typedef enum logic {
    WALK_IDLE = 1'b0,
    WALK_BUSY = 1'b1
  } walk_state_e;

  // Miss request from the first-level TLBs, 17 bits
  typedef struct packed {
    vpn_t      vpn;
    tlb_dest_e dest;
  } tlb_req_t;

  // Translation response, 29 bits
  typedef struct packed {
    vpn_t      vpn;
    ppn_t      ppn;
    tlb_dest_e dest;
  } tlb_resp_t;

endpackage

/* verilog/l2_tlb_top.sv */
// L2 TLB miss-handling core
// Shared ITLB/DTLB miss stream served by a direct-mapped array,
// an in-order MSHR and a single-walk controller

`timescale 1ns/10ps

module l2_tlb_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  req_valid_i,
  input  l2_tlb_pkg::tlb_req_t  req_i,
  output logic                  busy_o,
  output logic                  resp_valid_o,
  output l2_tlb_pkg::tlb_resp_t resp_o,
  output logic                  ptw_req_o,
  output l2_tlb_pkg::vpn_t      ptw_req_vpn_o,
  input  logic                  ptw_ans_valid_i,
  input  l2_tlb_pkg::ppn_t      ptw_ans_ppn_i
);

  import l2_tlb_pkg::*;

  // Array side
  logic      lookup;
  vpn_t      lookup_vpn;
  logic      fill;
  vpn_t      fill_vpn;
  ppn_t      fill_ppn;
  logic      lookup_done;
  logic      hit;
  ppn_t      hit_ppn;

  // MSHR side
  logic      add_entry;
  logic      let_entry_waiting;
  logic      rm_entry;
  tlb_req_t  add_req;
  logic      req_available;
  logic      mshr_full;
  vpn_t      ans_vpn;
  tlb_dest_e ans_dest;

  l2_tlb_array u_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .lookup_i      (lookup),
    .fill_i        (fill),
    .lookup_vpn_i  (lookup_vpn),
    .fill_vpn_i    (fill_vpn),
    .fill_ppn_i    (fill_ppn),
    .lookup_done_o (lookup_done),
    .hit_o         (hit),
    .ppn_o         (hit_ppn)
  );

  // Head VPN drives the walk request port directly
  l2_tlb_mshr u_mshr (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .clr_mshr_i          (flush_i),
    .add_entry_i         (add_entry),
    .rm_entry_i          (rm_entry),
    .let_entry_waiting_i (let_entry_waiting),
    .vpn_i               (add_req.vpn),
    .destination_i       (add_req.dest),
    .req_available_o     (req_available),
    .mshr_full_o         (mshr_full),
    .ptw_req_vpn_o       (ptw_req_vpn_o),
    .ptw_ans_vpn_o       (ans_vpn),
    .destination_o       (ans_dest)
  );

  l2_tlb_ctrl u_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .req_valid_i         (req_valid_i),
    .req_i               (req_i),
    .busy_o              (busy_o),
    .resp_valid_o        (resp_valid_o),
    .resp_o              (resp_o),
    .lookup_o            (lookup),
    .lookup_vpn_o        (lookup_vpn),
    .fill_o              (fill),
    .fill_vpn_o          (fill_vpn),
    .fill_ppn_o          (fill_ppn),
    .lookup_done_i       (lookup_done),
    .hit_i               (hit),
    .ppn_i               (hit_ppn),
    .add_entry_o         (add_entry),
    .let_entry_waiting_o (let_entry_waiting),
    .rm_entry_o          (rm_entry),
    .add_req_o           (add_req),
    .req_available_i     (req_available),
    .mshr_full_i         (mshr_full),
    .ptw_ans_vpn_i       (ans_vpn),
    .ptw_ans_dest_i      (ans_dest),
    .ptw_req_o           (ptw_req_o),
    .ptw_ans_valid_i     (ptw_ans_valid_i),
    .ptw_ans_ppn_i       (ptw_ans_ppn_i)
  );

endmodule
